// File: run_sim.sh
#!/bin/sh
# Build and run the memory-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_mem_stage \
	--Mdir obj_dir -o tb_mem_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mem_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: verification/tb_mem_stage.sv
`timescale 1ns/10ps

module tb_mem_stage;
	import mem_pkg::*;

	localparam word_t INST_PC    = 32'h0040_0100;
	localparam word_t FLAG_SYS   = 32'h0000_0100;
	localparam word_t FLAG_RI    = 32'h0000_0400;
	localparam word_t FLAG_ERET  = 32'h0000_1000;
	localparam int    MAX_CYCLES = 2000;

	logic      clk = 1'b0;
	logic      rst_n;
	mem_op_t   op;
	word_t     addr;
	word_t     reg2;
	reg_addr_t wd;
	logic      wreg;
	word_t     wdata;
	word_t     exc_flags;
	word_t     inst_addr;
	word_t     rdata;
	word_t     cp0_status;
	word_t     cp0_cause;
	word_t     cp0_epc;
	logic      wb_cp0_we;
	logic [CP0_ADDR_W-1:0] wb_cp0_addr;
	word_t     wb_cp0_data;

	word_t     mem_addr;
	logic      mem_we;
	lane_sel_t mem_sel;
	word_t     mem_wdata;
	logic      mem_ce;
	exc_code_t exc_code;
	word_t     exc_epc;
	word_t     bad_vaddr;
	logic      wb_wreg;
	reg_addr_t wb_wd;
	word_t     wb_wdata;

	word_t     rng_state = 32'd63143;
	int        check_count = 0;
	int        err_count = 0;
	logic      done = 1'b0;

	mem_stage_top u_mem_stage_top (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.op_i          (op),
		.mem_addr_i    (addr),
		.reg2_i        (reg2),
		.wd_i          (wd),
		.wreg_i        (wreg),
		.wdata_i       (wdata),
		.exc_flags_i   (exc_flags),
		.inst_addr_i   (inst_addr),
		.mem_data_i    (rdata),
		.cp0_status_i  (cp0_status),
		.cp0_cause_i   (cp0_cause),
		.cp0_epc_i     (cp0_epc),
		.wb_cp0_we_i   (wb_cp0_we),
		.wb_cp0_addr_i (wb_cp0_addr),
		.wb_cp0_data_i (wb_cp0_data),
		.mem_addr_o    (mem_addr),
		.mem_we_o      (mem_we),
		.mem_sel_o     (mem_sel),
		.mem_data_o    (mem_wdata),
		.mem_ce_o      (mem_ce),
		.exc_code_o    (exc_code),
		.exc_epc_o     (exc_epc),
		.bad_vaddr_o   (bad_vaddr),
		.wb_wreg_o     (wb_wreg),
		.wb_wd_o       (wb_wd),
		.wb_wdata_o    (wb_wdata)
	);

	always #5 clk = ~clk;

	function automatic word_t next_rand();
		word_t x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Register value after a load at byte offset n
	function automatic word_t expect_load(input mem_op_t o, input int n, input word_t md,
			input word_t r2);
		logic [7:0]  b;
		logic [15:0] h;
		word_t       res;
		int          i;
		b = md[8*n +: 8];
		h = md[16*(n/2) +: 16];
		res = '0;
		case (o)
			OP_LB:  res = {{24{b[7]}}, b};
			OP_LBU: res = {24'h0, b};
			OP_LH:  res = {{16{h[15]}}, h};
			OP_LHU: res = {16'h0, h};
			OP_LW:  res = md;
			OP_LWL: begin
				for (i = 0; i < 4; i++) begin
					if (i >= 3 - n)
						res[8*i +: 8] = md[8*(i-3+n) +: 8];
					else
						res[8*i +: 8] = r2[8*i +: 8];
				end
			end
			OP_LWR: begin
				for (i = 0; i < 4; i++) begin
					if (i < 4 - n)
						res[8*i +: 8] = md[8*(i+n) +: 8];
					else
						res[8*i +: 8] = r2[8*i +: 8];
				end
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	function automatic lane_sel_t expect_sel(input mem_op_t o, input int n);
		lane_sel_t sel;
		int        i;
		sel = '0;
		case (o)
			OP_LB, OP_LBU, OP_SB: sel[n] = 1'b1;
			OP_LH, OP_LHU, OP_SH: sel = (n >= 2) ? 4'b1100 : 4'b0011;
			OP_LW, OP_LWL, OP_LWR, OP_SW: sel = 4'b1111;
			OP_SWL: begin
				for (i = 0; i < 4; i++)
					sel[i] = (i <= n);
			end
			OP_SWR: begin
				for (i = 0; i < 4; i++)
					sel[i] = (i >= n);
			end
			default: sel = '0;
		endcase
		return sel;
	endfunction

	function automatic word_t expect_store(input mem_op_t o, input int n, input word_t r2);
		word_t res;
		int    i;
		res = '0;
		case (o)
			OP_SB: res = {4{r2[7:0]}};
			OP_SH: res = {2{r2[15:0]}};
			OP_SW: res = r2;
			OP_SWL: begin
				for (i = 0; i <= n; i++)
					res[8*i +: 8] = r2[8*(i+3-n) +: 8];
			end
			OP_SWR: begin
				for (i = n; i < 4; i++)
					res[8*i +: 8] = r2[8*(i-n) +: 8];
			end
			default: res = '0;
		endcase
		return res;
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (expected !== actual) begin
			err_count++;
			$display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Drives one instruction on the falling edge and lets the outputs settle
	task automatic apply(input mem_op_t o, input word_t a, input word_t r2, input word_t md,
			input logic wr, input word_t flags);
		@(negedge clk);
		op        = o;
		addr      = a;
		reg2      = r2;
		rdata     = md;
		wreg      = wr;
		exc_flags = flags;
		wd        = reg_addr_t'(next_rand());
		wdata     = next_rand();
		#2;
	endtask

	task automatic check_writeback(input logic exp_wreg, input word_t exp_data,
			input logic check_data);
		@(posedge clk);
		#1;
		check_value("wb_wreg_o", word_t'(exp_wreg), word_t'(wb_wreg));
		check_value("wb_wd_o", word_t'(wd), word_t'(wb_wd));
		if (check_data)
			check_value("wb_wdata_o", exp_data, wb_wdata);
	endtask

	task automatic go_idle();
		@(negedge clk);
		op        = OP_NONE;
		wreg      = 1'b0;
		exc_flags = '0;
		inst_addr = INST_PC;
		wb_cp0_we = 1'b0;
	endtask

	task automatic end_test(input string name, input int err_start);
		$display("%s finished with %0d errors", name, err_count - err_start);
	endtask

	task automatic test_loads();
		mem_op_t ops [0:4];
		int      err_start;
		int      j;
		int      k;
		word_t   a;
		word_t   md;
		word_t   r2;
		logic    skip;
		err_start = err_count;
		ops[0] = OP_LB;
		ops[1] = OP_LBU;
		ops[2] = OP_LH;
		ops[3] = OP_LHU;
		ops[4] = OP_LW;
		for (j = 0; j < 5; j++) begin
			for (k = 0; k < 4; k++) begin
				skip = ((ops[j] == OP_LH || ops[j] == OP_LHU) && (k % 2 != 0)) ||
					(ops[j] == OP_LW && k != 0);
				if (!skip) begin
					a = next_rand();
					a[1:0] = 2'(k);
					md = next_rand();
					r2 = next_rand();
					apply(ops[j], a, r2, md, 1'b1, '0);
					check_value("mem_sel_o", word_t'(expect_sel(ops[j], k)), word_t'(mem_sel));
					check_value("mem_ce_o", 32'd1, word_t'(mem_ce));
					check_writeback(1'b1, expect_load(ops[j], k, md, r2), 1'b1);
				end
			end
		end
		go_idle();
		end_test("test_loads", err_start);
	endtask

	task automatic test_unaligned_loads();
		int    err_start;
		int    j;
		int    k;
		word_t a;
		word_t md;
		word_t r2;
		err_start = err_count;
		for (j = 0; j < 2; j++) begin
			for (k = 0; k < 4; k++) begin
				a = next_rand();
				a[1:0] = 2'(k);
				md = next_rand();
				r2 = next_rand();
				apply(j == 0 ? OP_LWL : OP_LWR, a, r2, md, 1'b1, '0);
				check_value("mem_addr_o", {a[31:2], 2'b00}, mem_addr);
				check_writeback(1'b1, expect_load(j == 0 ? OP_LWL : OP_LWR, k, md, r2), 1'b1);
			end
		end
		go_idle();
		end_test("test_unaligned_loads", err_start);
	endtask

	task automatic test_stores();
		mem_op_t ops [0:4];
		int      err_start;
		int      j;
		int      k;
		word_t   a;
		word_t   r2;
		err_start = err_count;
		ops[0] = OP_SB;
		ops[1] = OP_SH;
		ops[2] = OP_SW;
		ops[3] = OP_SWL;
		ops[4] = OP_SWR;
		for (j = 0; j < 5; j++) begin
			for (k = 0; k < 4; k++) begin
				if (!((ops[j] == OP_SH && k % 2 != 0) || (ops[j] == OP_SW && k != 0))) begin
					a = next_rand();
					a[1:0] = 2'(k);
					r2 = next_rand();
					apply(ops[j], a, r2, next_rand(), 1'b0, '0);
					check_value("mem_data_o", expect_store(ops[j], k, r2), mem_wdata);
					check_value("mem_sel_o", word_t'(expect_sel(ops[j], k)), word_t'(mem_sel));
					if (ops[j] == OP_SWL || ops[j] == OP_SWR)
						check_value("mem_addr_o", {a[31:2], 2'b00}, mem_addr);
					else
						check_value("mem_addr_o", a, mem_addr);
					check_value("mem_we_o", 32'd1, word_t'(mem_we));
					check_value("mem_ce_o", 32'd1, word_t'(mem_ce));
				end
			end
		end
		go_idle();
		end_test("test_stores", err_start);
	endtask

	task automatic test_misaligned();
		mem_op_t ops [0:4];
		int      ofs [0:4];
		int      err_start;
		int      j;
		word_t   a;
		logic    is_store;
		err_start = err_count;
		ops[0] = OP_LH;
		ofs[0] = 1;
		ops[1] = OP_LHU;
		ofs[1] = 3;
		ops[2] = OP_LW;
		ofs[2] = 2;
		ops[3] = OP_SH;
		ofs[3] = 3;
		ops[4] = OP_SW;
		ofs[4] = 1;
		for (j = 0; j < 5; j++) begin
			is_store = (ops[j] == OP_SH || ops[j] == OP_SW);
			a = next_rand();
			a[1:0] = 2'(ofs[j]);
			apply(ops[j], a, next_rand(), next_rand(), 1'b1, '0);
			check_value("exc_code_o", word_t'(is_store ? EXC_ADES : EXC_ADEL),
				word_t'(exc_code));
			check_value("bad_vaddr_o", a, bad_vaddr);
			check_value("mem_ce_o", 32'd0, word_t'(mem_ce));
			check_value("mem_we_o", 32'd0, word_t'(mem_we));
			check_writeback(1'b0, '0, 1'b0);
		end
		go_idle();
		end_test("test_misaligned", err_start);
	endtask

	task automatic test_interrupt();
		int    err_start;
		word_t epc_wb;
		err_start = err_count;
		// Pending line 2 with mask and IE only through the writeback write
		@(negedge clk);
		cp0_status  = '0;
		cp0_cause   = 32'h0000_0400;
		wb_cp0_we   = 1'b1;
		wb_cp0_addr = CP0_STATUS;
		wb_cp0_data = 32'h0000_0401;
		wreg        = 1'b1;
		#2;
		check_value("exc_code_o", word_t'(EXC_INT), word_t'(exc_code));
		check_writeback(1'b0, '0, 1'b0);
		@(negedge clk);
		cp0_status  = 32'h0000_0401;
		wb_cp0_data = 32'h0000_0400;
		#2;
		check_value("exc_code_o", word_t'(EXC_NONE), word_t'(exc_code));
		@(negedge clk);
		cp0_epc     = next_rand();
		epc_wb      = next_rand();
		wb_cp0_addr = CP0_EPC;
		wb_cp0_data = epc_wb;
		#2;
		check_value("exc_epc_o", epc_wb, exc_epc);
		@(negedge clk);
		wb_cp0_we = 1'b0;
		#2;
		check_value("exc_epc_o", cp0_epc, exc_epc);
		@(negedge clk);
		cp0_status = '0;
		cp0_cause  = '0;
		go_idle();
		end_test("test_interrupt", err_start);
	endtask

	task automatic test_priority();
		int    err_start;
		word_t a;
		err_start = err_count;
		a = next_rand();
		a[1:0] = 2'b01;
		apply(OP_LW, a, next_rand(), next_rand(), 1'b0, FLAG_SYS | FLAG_RI | FLAG_ERET);
		check_value("exc_code_o", word_t'(EXC_ADEL), word_t'(exc_code));
		apply(OP_NONE, '0, '0, '0, 1'b0, FLAG_SYS | FLAG_RI);
		check_value("exc_code_o", word_t'(EXC_SYSCALL), word_t'(exc_code));
		apply(OP_NONE, '0, '0, '0, 1'b0, FLAG_RI | FLAG_ERET);
		check_value("exc_code_o", word_t'(EXC_RI), word_t'(exc_code));
		apply(OP_NONE, '0, '0, '0, 1'b0, FLAG_ERET);
		check_value("exc_code_o", word_t'(EXC_ERET), word_t'(exc_code));
		// A bubble raises nothing
		@(negedge clk);
		inst_addr = '0;
		exc_flags = FLAG_SYS | FLAG_RI | FLAG_ERET;
		#2;
		check_value("exc_code_o", word_t'(EXC_NONE), word_t'(exc_code));
		@(negedge clk);
		inst_addr = INST_PC;
		a = next_rand();
		a[1:0] = 2'b00;
		apply(OP_SW, a, next_rand(), '0, 1'b0, FLAG_SYS);
		check_value("exc_code_o", word_t'(EXC_SYSCALL), word_t'(exc_code));
		check_value("mem_we_o", 32'd0, word_t'(mem_we));
		go_idle();
		end_test("test_priority", err_start);
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (!done && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Simulation did not finish within %0d clock cycles", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		int i;
		rst_n       = 1'b0;
		op          = OP_NONE;
		addr        = '0;
		reg2        = '0;
		wd          = '0;
		wreg        = 1'b0;
		wdata       = '0;
		exc_flags   = '0;
		inst_addr   = INST_PC;
		rdata       = '0;
		cp0_status  = '0;
		cp0_cause   = '0;
		cp0_epc     = '0;
		wb_cp0_we   = 1'b0;
		wb_cp0_addr = '0;
		wb_cp0_data = '0;
		for (i = 0; i < 16; i++)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("wb_wreg_o", 32'd0, word_t'(wb_wreg));
		check_value("wb_wd_o", 32'd0, word_t'(wb_wd));
		check_value("wb_wdata_o", 32'd0, wb_wdata);

		test_loads();
		test_unaligned_loads();
		test_stores();
		test_misaligned();
		test_interrupt();
		test_priority();

		done = 1'b1;
		$display("Tests done: %0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: verilog/cp0_bypass.sv
`timescale 1ns/10ps

module cp0_bypass (
	input  mem_pkg::word_t                 cp0_status_i,
	input  mem_pkg::word_t                 cp0_cause_i,
	input  mem_pkg::word_t                 cp0_epc_i,
	input  logic                           wb_cp0_we_i,
	input  logic [mem_pkg::CP0_ADDR_W-1:0] wb_cp0_addr_i,
	input  mem_pkg::word_t                 wb_cp0_data_i,
	output mem_pkg::word_t                 status_o,
	output mem_pkg::word_t                 cause_o,
	output mem_pkg::word_t                 epc_o
);
	import mem_pkg::*;

	// Newest value of one register with the writeback write taking precedence
	function automatic word_t fwd(input logic [CP0_ADDR_W-1:0] reg_num, input word_t cur);
		logic hit;
		hit = wb_cp0_we_i && (wb_cp0_addr_i == reg_num);
		return hit ? wb_cp0_data_i : cur;
	endfunction

	always_comb begin
		status_o = fwd(CP0_STATUS, cp0_status_i);
		cause_o  = fwd(CP0_CAUSE, cp0_cause_i);
		epc_o    = fwd(CP0_EPC, cp0_epc_i);
	end

endmodule

// File: verilog/except_arbiter.sv
`timescale 1ns/10ps

module except_arbiter (
	input  mem_pkg::word_t     inst_addr_i,
	input  mem_pkg::word_t     exc_flags_i,
	input  logic               adel_i,
	input  logic               ades_i,
	input  logic               we_i,
	input  mem_pkg::word_t     status_i,
	input  mem_pkg::word_t     cause_i,
	output mem_pkg::exc_code_t exc_code_o,
	output logic               mem_we_o
);
	import mem_pkg::*;

	logic int_pending;
	logic int_taken;

	// Masked pending lines, only when enabled and not already in an exception
	assign int_pending = |(status_i[INT_FIELD_HI:INT_FIELD_LO] & cause_i[INT_FIELD_HI:INT_FIELD_LO]);
	assign int_taken   = int_pending && !status_i[STATUS_EXL_BIT] && status_i[STATUS_IE_BIT];

	always_comb begin
		exc_code_o = EXC_NONE;
		// A bubble carries no instruction address
		if (inst_addr_i != '0) begin
			if (int_taken) begin
				exc_code_o = EXC_INT;
			end else if (adel_i) begin
				exc_code_o = EXC_ADEL;
			end else if (ades_i) begin
				exc_code_o = EXC_ADES;
			end else if (exc_flags_i[EXC_FLAG_SYSCALL]) begin
				exc_code_o = EXC_SYSCALL;
			end else if (exc_flags_i[EXC_FLAG_RI]) begin
				exc_code_o = EXC_RI;
			end else if (exc_flags_i[EXC_FLAG_ERET]) begin
				exc_code_o = EXC_ERET;
			end
		end
	end

	// No memory write for a faulting instruction
	assign mem_we_o = we_i && (exc_code_o == EXC_NONE);

endmodule

// File: verilog/load_data_extract.sv
`timescale 1ns/10ps

module load_data_extract (
	input  mem_pkg::mem_op_t op_i,
	input  logic [1:0]       ofs_i,
	input  mem_pkg::word_t   mem_data_i,
	input  mem_pkg::word_t   reg2_i,
	input  mem_pkg::word_t   wdata_i,
	output mem_pkg::word_t   load_data_o
);
	import mem_pkg::*;

	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic [4:0]  left_sh;
	logic [4:0]  right_sh;
	word_t       lwl_data;
	word_t       lwr_data;

	assign ld_byte = mem_data_i[{ofs_i, 3'b000} +: 8];
	assign ld_half = mem_data_i[{ofs_i[1], 4'b0000} +: 16];

	// 8*(3-ofs) for LWL, 8*ofs for LWR
	assign left_sh  = {~ofs_i, 3'b000};
	assign right_sh = {ofs_i, 3'b000};

	// Memory bytes go to the top, register keeps the rest
	assign lwl_data = (mem_data_i << left_sh) | (reg2_i & ~(word_t'('1) << left_sh));
	assign lwr_data = (mem_data_i >> right_sh) | (reg2_i & ~(word_t'('1) >> right_sh));

	always_comb begin
		case (op_i)
			OP_LB: begin
				load_data_o = {{24{ld_byte[7]}}, ld_byte};
			end
			OP_LBU: begin
				load_data_o = {24'h0, ld_byte};
			end
			OP_LH: begin
				load_data_o = {{16{ld_half[15]}}, ld_half};
			end
			OP_LHU: begin
				load_data_o = {16'h0, ld_half};
			end
			OP_LW: begin
				load_data_o = mem_data_i;
			end
			OP_LWL: begin
				load_data_o = lwl_data;
			end
			OP_LWR: begin
				load_data_o = lwr_data;
			end
			default: begin
				load_data_o = wdata_i;
			end
		endcase
	end

endmodule

// File: verilog/mem_access_ctrl.sv
`timescale 1ns/10ps

module mem_access_ctrl (
	input  mem_pkg::mem_op_t   op_i,
	input  mem_pkg::word_t     mem_addr_i,
	output mem_pkg::word_t     mem_addr_o,
	output logic [1:0]         ofs_o,
	output mem_pkg::lane_sel_t sel_o,
	output logic               ce_o,
	output logic               we_o,
	output logic               adel_o,
	output logic               ades_o,
	output mem_pkg::word_t     bad_vaddr_o
);
	import mem_pkg::*;

	logic [1:0] ofs;
	word_t      word_addr;
	lane_sel_t  byte_lane;
	lane_sel_t  half_lanes;
	logic       half_ok;
	logic       word_ok;

	assign ofs        = mem_addr_i[1:0];
	assign ofs_o      = ofs;
	assign word_addr  = {mem_addr_i[WORD_W-1:2], 2'b00};
	assign byte_lane  = lane_sel_t'(1) << ofs;
	assign half_lanes = ofs[1] ? 4'b1100 : 4'b0011;
	assign half_ok    = ~ofs[0];
	assign word_ok    = (ofs == 2'b00);

	always_comb begin
		mem_addr_o = mem_addr_i;
		sel_o      = '0;
		ce_o       = 1'b0;
		we_o       = 1'b0;
		adel_o     = 1'b0;
		ades_o     = 1'b0;
		case (op_i)
			OP_LB, OP_LBU: begin
				ce_o  = 1'b1;
				sel_o = byte_lane;
			end
			OP_LH, OP_LHU: begin
				ce_o   = half_ok;
				sel_o  = half_lanes;
				adel_o = ~half_ok;
			end
			OP_LW: begin
				ce_o   = word_ok;
				sel_o  = '1;
				adel_o = ~word_ok;
			end
			OP_LWL, OP_LWR: begin
				mem_addr_o = word_addr;
				ce_o       = 1'b1;
				sel_o      = '1;
			end
			OP_SB: begin
				ce_o  = 1'b1;
				we_o  = 1'b1;
				sel_o = byte_lane;
			end
			OP_SH: begin
				ce_o   = half_ok;
				we_o   = 1'b1;
				sel_o  = half_ok ? half_lanes : 4'b0000;
				ades_o = ~half_ok;
			end
			OP_SW: begin
				ce_o   = word_ok;
				we_o   = 1'b1;
				sel_o  = word_ok ? 4'b1111 : 4'b0000;
				ades_o = ~word_ok;
			end
			OP_SWL: begin
				// Lanes 0 up to the offset
				mem_addr_o = word_addr;
				ce_o       = 1'b1;
				we_o       = 1'b1;
				sel_o      = ~(lane_sel_t'(4'b1110) << ofs);
			end
			OP_SWR: begin
				// Lanes from the offset up to 3
				mem_addr_o = word_addr;
				ce_o       = 1'b1;
				we_o       = 1'b1;
				sel_o      = lane_sel_t'(4'b1111) << ofs;
			end
			default: begin
			end
		endcase
	end

	assign bad_vaddr_o = (adel_o | ades_o) ? mem_addr_i : '0;

endmodule

// File: verilog/mem_pkg.sv
package mem_pkg;

	// Datapath widths
	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int LANES      = 4;
	localparam int CP0_ADDR_W = 5;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [LANES-1:0]      lane_sel_t;

	// Memory operation from the execute stage
	typedef enum logic [3:0] {
		OP_NONE,
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_LWL,
		OP_LWR,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_SWL,
		OP_SWR
	} mem_op_t;

	// Coprocessor 0 register numbers
	localparam logic [CP0_ADDR_W-1:0] CP0_STATUS = 5'd12;
	localparam logic [CP0_ADDR_W-1:0] CP0_CAUSE  = 5'd13;
	localparam logic [CP0_ADDR_W-1:0] CP0_EPC    = 5'd14;

	// Status and Cause fields
	localparam int STATUS_IE_BIT  = 0;
	localparam int STATUS_EXL_BIT = 1;
	localparam int INT_FIELD_LO   = 8;
	localparam int INT_FIELD_HI   = 15;

	// Positions in the incoming exception flag word
	localparam int EXC_FLAG_SYSCALL = 8;
	localparam int EXC_FLAG_RI      = 10;
	localparam int EXC_FLAG_ERET    = 12;

	typedef logic [4:0] exc_code_t;

	localparam exc_code_t EXC_NONE    = 5'd0;
	localparam exc_code_t EXC_INT     = 5'd1;
	localparam exc_code_t EXC_ADEL    = 5'd4;
	localparam exc_code_t EXC_ADES    = 5'd5;
	localparam exc_code_t EXC_SYSCALL = 5'd8;
	localparam exc_code_t EXC_RI      = 5'd10;
	localparam exc_code_t EXC_ERET    = 5'd14;

endpackage

// File: verilog/mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top (
	input  logic                       clk,
	input  logic                       rst_n_i,
	input  mem_pkg::mem_op_t           op_i,
	input  mem_pkg::word_t             mem_addr_i,
	input  mem_pkg::word_t             reg2_i,
	input  mem_pkg::reg_addr_t         wd_i,
	input  logic                       wreg_i,
	input  mem_pkg::word_t             wdata_i,
	input  mem_pkg::word_t             exc_flags_i,
	input  mem_pkg::word_t             inst_addr_i,
	input  mem_pkg::word_t             mem_data_i,
	input  mem_pkg::word_t             cp0_status_i,
	input  mem_pkg::word_t             cp0_cause_i,
	input  mem_pkg::word_t             cp0_epc_i,
	input  logic                       wb_cp0_we_i,
	input  logic [mem_pkg::CP0_ADDR_W-1:0] wb_cp0_addr_i,
	input  mem_pkg::word_t             wb_cp0_data_i,
	output mem_pkg::word_t             mem_addr_o,
	output logic                       mem_we_o,
	output mem_pkg::lane_sel_t         mem_sel_o,
	output mem_pkg::word_t             mem_data_o,
	output logic                       mem_ce_o,
	output mem_pkg::exc_code_t         exc_code_o,
	output mem_pkg::word_t             exc_epc_o,
	output mem_pkg::word_t             bad_vaddr_o,
	output logic                       wb_wreg_o,
	output mem_pkg::reg_addr_t         wb_wd_o,
	output mem_pkg::word_t             wb_wdata_o
);
	import mem_pkg::*;

	logic [1:0] ofs;
	logic       req_we;
	logic       load_adel;
	logic       store_ades;
	word_t      load_data;
	word_t      status_fw;
	word_t      cause_fw;

	// Request decode and alignment checks
	mem_access_ctrl u_mem_access_ctrl (
		.op_i        (op_i),
		.mem_addr_i  (mem_addr_i),
		.mem_addr_o  (mem_addr_o),
		.ofs_o       (ofs),
		.sel_o       (mem_sel_o),
		.ce_o        (mem_ce_o),
		.we_o        (req_we),
		.adel_o      (load_adel),
		.ades_o      (store_ades),
		.bad_vaddr_o (bad_vaddr_o)
	);

	load_data_extract u_load_data_extract (
		.op_i        (op_i),
		.ofs_i       (ofs),
		.mem_data_i  (mem_data_i),
		.reg2_i      (reg2_i),
		.wdata_i     (wdata_i),
		.load_data_o (load_data)
	);

	store_data_align u_store_data_align (
		.op_i         (op_i),
		.ofs_i        (ofs),
		.reg2_i       (reg2_i),
		.store_data_o (mem_data_o)
	);

	cp0_bypass u_cp0_bypass (
		.cp0_status_i  (cp0_status_i),
		.cp0_cause_i   (cp0_cause_i),
		.cp0_epc_i     (cp0_epc_i),
		.wb_cp0_we_i   (wb_cp0_we_i),
		.wb_cp0_addr_i (wb_cp0_addr_i),
		.wb_cp0_data_i (wb_cp0_data_i),
		.status_o      (status_fw),
		.cause_o       (cause_fw),
		.epc_o         (exc_epc_o)
	);

	except_arbiter u_except_arbiter (
		.inst_addr_i (inst_addr_i),
		.exc_flags_i (exc_flags_i),
		.adel_i      (load_adel),
		.ades_i      (store_ades),
		.we_i        (req_we),
		.status_i    (status_fw),
		.cause_i     (cause_fw),
		.exc_code_o  (exc_code_o),
		.mem_we_o    (mem_we_o)
	);

	// Results toward writeback
	mem_wb_reg u_mem_wb_reg (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.exc_code_i (exc_code_o),
		.wreg_i     (wreg_i),
		.wd_i       (wd_i),
		.data_i     (load_data),
		.wb_wreg_o  (wb_wreg_o),
		.wb_wd_o    (wb_wd_o),
		.wb_wdata_o (wb_wdata_o)
	);

endmodule

// File: verilog/mem_wb_reg.sv
`timescale 1ns/10ps

module mem_wb_reg (
	input  logic               clk,
	input  logic               rst_n_i,
	input  mem_pkg::exc_code_t exc_code_i,
	input  logic               wreg_i,
	input  mem_pkg::reg_addr_t wd_i,
	input  mem_pkg::word_t     data_i,
	output logic               wb_wreg_o,
	output mem_pkg::reg_addr_t wb_wd_o,
	output mem_pkg::word_t     wb_wdata_o
);
	import mem_pkg::*;

	logic flush;

	assign flush = (exc_code_i != EXC_NONE);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_wreg_o  <= 1'b0;
			wb_wd_o    <= '0;
			wb_wdata_o <= '0;
		end else begin
			// Faulting instruction must not reach the register file
			wb_wreg_o  <= wreg_i && !flush;
			wb_wd_o    <= wd_i;
			wb_wdata_o <= data_i;
		end
	end

endmodule

// File: verilog/store_data_align.sv
`timescale 1ns/10ps

module store_data_align (
	input  mem_pkg::mem_op_t op_i,
	input  logic [1:0]       ofs_i,
	input  mem_pkg::word_t   reg2_i,
	output mem_pkg::word_t   store_data_o
);
	import mem_pkg::*;

	always_comb begin
		case (op_i)
			OP_SB: begin
				// Byte copied to every lane, sel picks one
				store_data_o = {LANES{reg2_i[7:0]}};
			end
			OP_SH: begin
				store_data_o = {2{reg2_i[15:0]}};
			end
			OP_SW: begin
				store_data_o = reg2_i;
			end
			OP_SWL: begin
				store_data_o = reg2_i >> {~ofs_i, 3'b000};
			end
			OP_SWR: begin
				store_data_o = reg2_i << {ofs_i, 3'b000};
			end
			default: begin
				store_data_o = '0;
			end
		endcase
	end

endmodule

// File: vlog.f
verilog/mem_pkg.sv
verilog/mem_access_ctrl.sv
verilog/load_data_extract.sv
verilog/store_data_align.sv
verilog/cp0_bypass.sv
verilog/except_arbiter.sv
verilog/mem_wb_reg.sv
verilog/mem_stage_top.sv
verification/tb_mem_stage.sv
